/* rtl/line_code_pkg.sv */
// 8b/10b line code constants, imported by the receive datapath and the testbench model
package line_code_pkg;

    // ----------------------------------------------------------------------
    // bit order
    // ----------------------------------------------------------------------
    // code group bit 0 is a, the first bit on the wire
    // bits 0..9 carry a b c d e i f g h j
    // byte bit 0 is A, bit 7 is H

    // width of one code group
    localparam int WORD_W = 10;
    // width of one decoded byte
    localparam int BYTE_W = 8;

    // ----------------------------------------------------------------------
    // comma detection
    // ----------------------------------------------------------------------
    // comma spans a b c d e i f
    localparam int COMMA_W = 7;

    // stored with a in bit 0
    // on the wire these read 0011111 and 1100000
    localparam logic [COMMA_W-1:0] COMMA_NEG = 7'b1111100;
    localparam logic [COMMA_W-1:0] COMMA_POS = 7'b0000011;

    // ----------------------------------------------------------------------
    // K codes that hold a comma
    // ----------------------------------------------------------------------
    localparam logic [BYTE_W-1:0] K28_1 = 8'h3C;
    // idle comma
    localparam logic [BYTE_W-1:0] K28_5 = 8'hBC;
    localparam logic [BYTE_W-1:0] K28_7 = 8'hFC;

endpackage

/* rtl/rx_status_pkg.sv */
// receive status types and defaults, imported by the checker, the output stage and the top
package rx_status_pkg;

    // ----------------------------------------------------------------------
    // running disparity
    // ----------------------------------------------------------------------
    // link starts at negative after reset
    typedef enum logic {
        RD_NEG = 1'b0,
        RD_POS = 1'b1
    } rd_t;

    // ----------------------------------------------------------------------
    // error counter
    // ----------------------------------------------------------------------
    // default width, top level may override
    localparam int DEFAULT_ERR_COUNT_W = 8;

endpackage

/* rtl/comma_aligner.sv */
// receive input stage, finds the comma in the raw word stream and emits aligned code groups
module comma_aligner
    import line_code_pkg::*;
(
    input  logic              i_decode_clk,
    input  logic              i_decode_reset,
    input  logic [WORD_W-1:0] i_rx_word,
    input  logic              i_rx_valid,
    output logic [WORD_W-1:0] o_aligned_word,
    output logic              o_aligned_valid,
    output logic              o_locked
);

    localparam int OFF_W = $clog2(WORD_W);

    // previous word, older half of the window
    logic [WORD_W-1:0]   prev_word;
    // oldest bit sits at position 0
    logic [2*WORD_W-1:0] window;
    // current lock offset
    logic [OFF_W-1:0]    lock_off;
    // comma search result
    logic                hit;
    logic [OFF_W-1:0]    hit_off;
    // offset used for this word
    logic [OFF_W-1:0]    sel_off;

    assign window = {i_rx_word, prev_word};

    // ----------------------------------------------------------------------
    // comma search over offsets 0..9
    // ----------------------------------------------------------------------
    // walks down so the lowest offset wins
    always_comb begin
        hit     = 1'b0;
        hit_off = '0;
        for (int k = WORD_W - 1; k >= 0; k--) begin
            if (window[k +: COMMA_W] == COMMA_NEG ||
                window[k +: COMMA_W] == COMMA_POS) begin
                hit     = 1'b1;
                hit_off = OFF_W'(k);
            end
        end
    end

    // new comma takes effect at once so the comma group passes through
    assign sel_off = hit ? hit_off : lock_off;

    // ----------------------------------------------------------------------
    // lock state
    // ----------------------------------------------------------------------
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            prev_word       <= '0;
            lock_off        <= '0;
            o_locked        <= 1'b0;
            o_aligned_valid <= 1'b0;
        end else begin
            // strobe only once a comma has been seen
            o_aligned_valid <= i_rx_valid && (o_locked || hit);
            if (i_rx_valid) begin
                prev_word <= i_rx_word;
                // relock on a comma at any offset
                if (hit) begin
                    o_locked <= 1'b1;
                    lock_off <= hit_off;
                end
            end
        end
    end

    // aligned group register
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            o_aligned_word <= '0;
        end else if (i_rx_valid) begin
            o_aligned_word <= window[sel_off +: WORD_W];
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // every aligned group comes from a word taken while locked
    a_valid_locked : assert property (
        @(posedge i_decode_clk) disable iff (i_decode_reset)
        o_aligned_valid |-> o_locked && $past(i_rx_valid)
    );

endmodule

/* rtl/decode_8b10b.sv */
// 8b/10b decoder, turns one aligned code group into a byte and a K flag after one register
module decode_8b10b (
    input  logic i_decode_clk,
    input  logic i_decode_reset,
    input  logic i_datain_valid,
    // code group, a first on the wire
    input  logic ai, bi, ci, di, ei, ii,
    input  logic fi, gi, hi, ji,
    output logic o_comma_k,
    // decoded byte, H is the msb
    output logic HO, GO, FO, EO, DO, CO, BO, AO
);

    // ----------------------------------------------------------------------
    // 6b classification
    // ----------------------------------------------------------------------
    logic aneb, cned, eei;
    // ones count in abcd, one three or two
    logic p13, p31, p22;

    assign aneb = ai ^ bi;
    assign cned = ci ^ di;
    assign eei  = ~(ei ^ ii);

    assign p13 = (aneb & ~ci & ~di) | (cned & ~ai & ~bi);
    assign p31 = (aneb & ci & di) | (cned & ai & bi);
    assign p22 = (ai & bi & ~ci & ~di) | (ci & di & ~ai & ~bi) | (aneb & cned);

    // ----------------------------------------------------------------------
    // K detection
    // ----------------------------------------------------------------------
    logic ika, ikb, ikc;

    // K28.y, cdei all equal
    assign ika = (ci & di & ei & ii) | (~ci & ~di & ~ei & ~ii);
    // K23/27/29/30 from either disparity
    assign ikb = p13 & ~ei & ii & gi & hi & ji;
    assign ikc = p31 & ei & ~ii & ~gi & ~hi & ~ji;

    // ----------------------------------------------------------------------
    // 5b decode
    // ----------------------------------------------------------------------
    logic or121, or122, or123, or124, or125, or126, or127;
    // invert masks for a..e
    logic xa, xb, xc, xd, xe;

    assign or121 = (p22 & ~ai & ~ci & eei) | (p13 & ~ei);
    assign or122 = (ai & bi & ei & ii) | (~ci & ~di & ~ei & ~ii) | (p31 & ii);
    assign or123 = (p31 & ii) | (p22 & bi & ci & eei) | (p13 & di & ei & ii);
    assign or124 = (p22 & ai & ci & eei) | (p13 & ~ei);
    assign or125 = (p13 & ~ei) | (~ci & ~di & ~ei & ~ii) | (~ai & ~bi & ~ei & ~ii);
    assign or126 = (p22 & ~ai & ~ci & eei) | (p13 & ~ii);
    assign or127 = (p13 & di & ei & ii) | (p22 & ~bi & ~ci & eei);

    assign xa = or127 | or121 | or122;
    assign xb = or122 | or123 | or124;
    assign xc = or121 | or123 | or125;
    assign xd = or122 | or124 | or127;
    assign xe = or125 | or126 | or127;

    // ----------------------------------------------------------------------
    // 3b decode
    // ----------------------------------------------------------------------
    // K28 with h != j, flips all of fgh
    logic ior134;
    logic or131, or132, or133, or134;
    // invert masks for f..h
    logic xf, xg, xh;

    assign ior134 = ~(hi & ji) & ~(~hi & ~ji) & ~ci & ~di & ~ei & ~ii;

    assign or131 = (gi & hi & ji) | (fi & hi & ji) | ior134;
    assign or132 = (fi & gi & ji) | (~fi & ~gi & ~hi) | (~fi & ~gi & hi & ji);
    assign or133 = (~fi & ~hi & ~ji) | ior134 | (~gi & ~hi & ~ji);
    assign or134 = (~gi & ~hi & ~ji) | (fi & hi & ji) | ior134;

    assign xf = or131 | or132;
    assign xg = or132 | or133;
    assign xh = or132 | or134;

    // ----------------------------------------------------------------------
    // output registers
    // ----------------------------------------------------------------------
    // K flag
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            o_comma_k <= 1'b0;
        end else if (i_datain_valid) begin
            o_comma_k <= ika | ikb | ikc;
        end
    end

    // decoded byte, loaded with each valid group
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            AO <= 1'b0;
            BO <= 1'b0;
            CO <= 1'b0;
            DO <= 1'b0;
            EO <= 1'b0;
            FO <= 1'b0;
            GO <= 1'b0;
            HO <= 1'b0;
        end else if (i_datain_valid) begin
            AO <= xa ^ ai;
            BO <= xb ^ bi;
            CO <= xc ^ ci;
            DO <= xd ^ di;
            EO <= xe ^ ei;
            FO <= xf ^ fi;
            GO <= xg ^ gi;
            HO <= xh ^ hi;
        end
    end

endmodule

/* rtl/disparity_checker.sv */
// receive checker, tracks running disparity and flags code and disparity errors per group
module disparity_checker
    import line_code_pkg::*;
    import rx_status_pkg::*;
(
    input  logic              i_decode_clk,
    input  logic              i_decode_reset,
    input  logic [WORD_W-1:0] i_word,
    input  logic              i_valid,
    output logic              o_disp_err,
    output logic              o_code_err,
    output logic              o_valid
);

    // balanced sub-blocks that still carry a polarity, a in bit 0
    // abcdei 111000 and 000111
    localparam logic [5:0] SUB6_NEG = 6'b000111;
    localparam logic [5:0] SUB6_POS = 6'b111000;
    // fghj 1100 and 0011
    localparam logic [3:0] SUB4_NEG = 4'b0011;
    localparam logic [3:0] SUB4_POS = 4'b1100;

    rd_t  rd;
    rd_t  rd_mid;
    rd_t  rd_next;
    logic code6, disp6;
    logic code4, disp4;

    // ----------------------------------------------------------------------
    // sub-block rule
    // ----------------------------------------------------------------------
    // mid is the balanced ones count of the sub-block
    // end disparity follows the received sub-block, even on an error
    function automatic void judge(
        input  int unsigned ones,
        input  int unsigned mid,
        input  logic        sp_neg,
        input  logic        sp_pos,
        input  rd_t         rd_in,
        output logic        code_err,
        output logic        disp_err,
        output rd_t         rd_out
    );
        code_err = 1'b0;
        disp_err = 1'b0;
        rd_out   = rd_in;
        if (sp_neg) begin
            disp_err = (rd_in == RD_POS);
            rd_out   = RD_NEG;
        end else if (sp_pos) begin
            disp_err = (rd_in == RD_NEG);
            rd_out   = RD_POS;
        end else if (ones == mid + 1) begin
            disp_err = (rd_in == RD_POS);
            rd_out   = RD_POS;
        end else if (ones + 1 == mid) begin
            disp_err = (rd_in == RD_NEG);
            rd_out   = RD_NEG;
        end else if (ones != mid) begin
            code_err = 1'b1;
            rd_out   = (ones > mid) ? RD_POS : RD_NEG;
        end
    endfunction

    // 4b judged against the disparity left by the 6b
    always_comb begin
        judge($countones(i_word[5:0]), 3, i_word[5:0] == SUB6_NEG,
              i_word[5:0] == SUB6_POS, rd, code6, disp6, rd_mid);
        judge($countones(i_word[9:6]), 2, i_word[9:6] == SUB4_NEG,
              i_word[9:6] == SUB4_POS, rd_mid, code4, disp4, rd_next);
    end

    // ----------------------------------------------------------------------
    // registers, in step with the decoder
    // ----------------------------------------------------------------------
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            rd         <= RD_NEG;
            o_valid    <= 1'b0;
            o_code_err <= 1'b0;
            o_disp_err <= 1'b0;
        end else begin
            o_valid    <= i_valid;
            o_code_err <= i_valid && (code6 || code4);
            o_disp_err <= i_valid && (disp6 || disp4);
            if (i_valid) begin
                rd <= rd_next;
            end
        end
    end

    // flags only ever travel with a group
    a_err_with_valid : assert property (
        @(posedge i_decode_clk) disable iff (i_decode_reset)
        !o_valid |-> !(o_disp_err || o_code_err)
    );

endmodule

/* rtl/rx_byte_output.sv */
// receive output stage, registers the decoded byte and flags under one strobe and counts errors
module rx_byte_output
    import line_code_pkg::*;
    import rx_status_pkg::*;
#(
    parameter int ERR_COUNT_W = DEFAULT_ERR_COUNT_W
) (
    input  logic                   i_decode_clk,
    input  logic                   i_decode_reset,
    input  logic [BYTE_W-1:0]      i_byte,
    input  logic                   i_is_k,
    input  logic                   i_disp_err,
    input  logic                   i_code_err,
    input  logic                   i_valid,
    output logic [BYTE_W-1:0]      o_byte,
    output logic                   o_is_k,
    output logic                   o_disp_err,
    output logic                   o_code_err,
    output logic                   o_byte_valid,
    output logic [ERR_COUNT_W-1:0] o_error_count
);

    // group carries at least one error flag
    logic bad_group;

    assign bad_group = i_valid && (i_disp_err || i_code_err);

    // ----------------------------------------------------------------------
    // flags, strobe and counter
    // ----------------------------------------------------------------------
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            o_byte_valid  <= 1'b0;
            o_is_k        <= 1'b0;
            o_disp_err    <= 1'b0;
            o_code_err    <= 1'b0;
            o_error_count <= '0;
        end else begin
            o_byte_valid <= i_valid;
            if (i_valid) begin
                o_is_k     <= i_is_k;
                o_disp_err <= i_disp_err;
                o_code_err <= i_code_err;
            end
            // saturates at all ones
            if (bad_group && !(&o_error_count)) begin
                o_error_count <= o_error_count + 1'b1;
            end
        end
    end

    // byte payload
    always_ff @(posedge i_decode_clk or posedge i_decode_reset) begin
        if (i_decode_reset) begin
            o_byte <= '0;
        end else if (i_valid) begin
            o_byte <= i_byte;
        end
    end

    a_count_monotonic : assert property (
        @(posedge i_decode_clk) disable iff (i_decode_reset)
        o_error_count >= $past(o_error_count)
    );

endmodule

/* rtl/decode_rx_top.sv */
// receive top level, joins the comma aligner, decoder, disparity checker and output stage
module decode_rx_top
    import line_code_pkg::*;
    import rx_status_pkg::*;
#(
    parameter int ERR_COUNT_W = DEFAULT_ERR_COUNT_W
) (
    input  logic                   i_decode_clk,
    input  logic                   i_decode_reset,
    input  logic [WORD_W-1:0]      i_rx_word,
    input  logic                   i_rx_valid,
    output logic [BYTE_W-1:0]      o_byte,
    output logic                   o_is_k,
    output logic                   o_disp_err,
    output logic                   o_code_err,
    output logic                   o_byte_valid,
    output logic [ERR_COUNT_W-1:0] o_error_count,
    output logic                   o_locked
);

    // ----------------------------------------------------------------------
    // aligner to decoder and checker
    // ----------------------------------------------------------------------
    logic [WORD_W-1:0] aligned_word;
    logic              aligned_valid;

    // ----------------------------------------------------------------------
    // decoder and checker to output stage
    // ----------------------------------------------------------------------
    logic [BYTE_W-1:0] dec_byte;
    logic              comma_k;
    logic              disp_err;
    logic              code_err;
    logic              check_valid;

    comma_aligner u_aligner (
        .i_decode_clk    (i_decode_clk),
        .i_decode_reset  (i_decode_reset),
        .i_rx_word       (i_rx_word),
        .i_rx_valid      (i_rx_valid),
        .o_aligned_word  (aligned_word),
        .o_aligned_valid (aligned_valid),
        .o_locked        (o_locked)
    );

    // group bits a..j in word order
    decode_8b10b u_decoder (
        .i_decode_clk   (i_decode_clk),
        .i_decode_reset (i_decode_reset),
        .i_datain_valid (aligned_valid),
        .ai (aligned_word[0]), .bi (aligned_word[1]), .ci (aligned_word[2]),
        .di (aligned_word[3]), .ei (aligned_word[4]), .ii (aligned_word[5]),
        .fi (aligned_word[6]), .gi (aligned_word[7]), .hi (aligned_word[8]),
        .ji (aligned_word[9]),
        .o_comma_k      (comma_k),
        .HO (dec_byte[7]), .GO (dec_byte[6]), .FO (dec_byte[5]), .EO (dec_byte[4]),
        .DO (dec_byte[3]), .CO (dec_byte[2]), .BO (dec_byte[1]), .AO (dec_byte[0])
    );

    disparity_checker u_checker (
        .i_decode_clk   (i_decode_clk),
        .i_decode_reset (i_decode_reset),
        .i_word         (aligned_word),
        .i_valid        (aligned_valid),
        .o_disp_err     (disp_err),
        .o_code_err     (code_err),
        .o_valid        (check_valid)
    );

    rx_byte_output #(
        .ERR_COUNT_W (ERR_COUNT_W)
    ) u_output (
        .i_decode_clk   (i_decode_clk),
        .i_decode_reset (i_decode_reset),
        .i_byte         (dec_byte),
        .i_is_k         (comma_k),
        .i_disp_err     (disp_err),
        .i_code_err     (code_err),
        .i_valid        (check_valid),
        .o_byte         (o_byte),
        .o_is_k         (o_is_k),
        .o_disp_err     (o_disp_err),
        .o_code_err     (o_code_err),
        .o_byte_valid   (o_byte_valid),
        .o_error_count  (o_error_count)
    );

endmodule

/* testbench/line_code_model.svh */
// 8b/10b reference encoder and violation rule, included into the testbench top module
`ifndef LINE_CODE_MODEL_SVH
`define LINE_CODE_MODEL_SVH

// ----------------------------------------------------------------------
// code tables, RD- column, a or f in the msb
// ----------------------------------------------------------------------
function automatic logic [5:0] sub6_from_neg(input int x);
    logic [5:0] t [32];
    t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001,
          6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100,
          6'b011100, 6'b010111, 6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011,
          6'b101010, 6'b011010, 6'b111010, 6'b110011, 6'b100110, 6'b010110, 6'b110110,
          6'b001110, 6'b101110, 6'b011110, 6'b101011};
    return t[x];
endfunction

function automatic logic [3:0] sub4_from_neg(input int y);
    logic [3:0] t [8];
    t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
    return t[y];
endfunction

// one group from the current disparity, result has a in bit 0
function automatic logic [9:0] encode_group(input logic [7:0] b, input logic k, inout bit rd);
    int x;
    int y;
    logic [5:0] s6;
    logic [3:0] s4;
    logic [9:0] t;
    logic [9:0] w;
    x = b[4:0];
    y = b[7:5];
    s6 = (k && x == 28) ? 6'b001111 : sub6_from_neg(x);
    // D.7 is balanced but still flips with disparity
    if (rd && ($countones(s6) != 3 || s6 == 6'b111000))
        s6 = ~s6;
    if ($countones(s6) != 3)
        rd = ($countones(s6) > 3);
    s4 = sub4_from_neg(y);
    // alternate .7 avoids a run of five
    if (y == 7 && (k || (!rd && (x == 17 || x == 18 || x == 20))
                    || (rd && (x == 11 || x == 13 || x == 14))))
        s4 = 4'b0111;
    // K28 balanced fghj are inverted after a negative 6b
    if (k && !rd && (y == 1 || y == 2 || y == 5 || y == 6))
        s4 = ~s4;
    if (rd && ($countones(s4) != 2 || s4 == 4'b1100))
        s4 = ~s4;
    if ($countones(s4) != 2)
        rd = ($countones(s4) > 2);
    t = {s6, s4};
    for (int i = 0; i < 10; i++)
        w[i] = t[9-i];
    return w;
endfunction

// ----------------------------------------------------------------------
// violation rule
// ----------------------------------------------------------------------
// sp_n legal only from negative, sp_p only from positive
function automatic void judge_sub(input int ones, input int mid, input bit sp_n, input bit sp_p,
                                  inout bit rd, inout bit code_err, inout bit disp_err);
    if (sp_n) begin
        disp_err |= rd;
        rd = 1'b0;
    end else if (sp_p) begin
        disp_err |= !rd;
        rd = 1'b1;
    end else if (ones == mid + 1) begin
        disp_err |= rd;
        rd = 1'b1;
    end else if (ones == mid - 1) begin
        disp_err |= !rd;
        rd = 1'b0;
    end else if (ones != mid) begin
        code_err = 1'b1;
        rd = (ones > mid);
    end
endfunction

// 4b judged against the disparity the 6b left
function automatic void check_group(input logic [9:0] w, inout bit rd,
                                    output bit code_err, output bit disp_err);
    logic [9:0] t;
    for (int i = 0; i < 10; i++)
        t[i] = w[9-i];
    code_err = 1'b0;
    disp_err = 1'b0;
    judge_sub($countones(t[9:4]), 3, t[9:4] == 6'b111000, t[9:4] == 6'b000111,
              rd, code_err, disp_err);
    judge_sub($countones(t[3:0]), 2, t[3:0] == 4'b1100, t[3:0] == 4'b0011,
              rd, code_err, disp_err);
endfunction

`endif

/* testbench/tb_decode_rx_top.sv */
// testbench for the 8b/10b receive path, run as the simulation top with decode_rx_top as DUT
module tb_decode_rx_top
    import line_code_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic              decode_clk;
    logic              decode_reset;
    logic [WORD_W-1:0] rx_word;
    logic              rx_valid;
    logic [BYTE_W-1:0] out_byte;
    logic              out_is_k, out_disp_err, out_code_err, out_byte_valid, out_locked;
    logic [3:0]        out_err_count;

    // encoder disparity and bits not yet sent
    bit         tx_rd;
    bit         pending[$];
    // every bit sent, led by the reset value of the previous word
    bit         stream[$];
    // start of each clean group, K flag in bit 8
    logic [8:0] group_at[int];
    // receive side model state
    bit         model_locked;
    int         model_off;
    bit         rx_rd;
    int         model_count;
    // {count, code, disp, care, k, byte}
    logic [15:0] exp_q[$];
    logic [2:0]  vhist;
    int          errors, checks;
    string       test_name;
    logic [7:0]  k_codes [12] = '{8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC,
                                  8'hF7, 8'hFB, 8'hFD, 8'hFE};

    `include "line_code_model.svh"

    decode_rx_top #(.ERR_COUNT_W(4)) uut (
        .i_decode_clk (decode_clk), .i_decode_reset (decode_reset),
        .i_rx_word (rx_word), .i_rx_valid (rx_valid),
        .o_byte (out_byte), .o_is_k (out_is_k), .o_disp_err (out_disp_err),
        .o_code_err (out_code_err), .o_byte_valid (out_byte_valid),
        .o_error_count (out_err_count), .o_locked (out_locked)
    );

    initial decode_clk = 1'b0;
    always #50 decode_clk = ~decode_clk;

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic put_code(input logic [7:0] b, input logic k);
        logic [9:0] w;
        w = encode_group(b, k, tx_rd);
        group_at[stream.size() + pending.size()] = {k, b};
        for (int i = 0; i < WORD_W; i++)
            pending.push_back(w[i]);
    endtask

    // alternating bits hold no comma
    task automatic insert_bits(input int n);
        for (int i = 0; i < n; i++)
            pending.push_back(i % 2);
    endtask

    task automatic flip_bit(input int pos);
        int s;
        s = pending.size() - WORD_W;
        pending[s + pos] = !pending[s + pos];
        group_at.delete(stream.size() + s);
    endtask

    // aligner rule applied to each word, then the violation rule per group
    function automatic void model_word(input logic [WORD_W-1:0] w);
        int base;
        int s;
        logic [6:0] c;
        logic [9:0] g;
        bit ce, de, care;
        base = stream.size();
        for (int i = 0; i < WORD_W; i++)
            stream.push_back(w[i]);
        for (int k = 0; k < WORD_W; k++) begin
            for (int j = 0; j < 7; j++)
                c[j] = stream[base - WORD_W + k + j];
            if (c == COMMA_NEG || c == COMMA_POS) begin
                model_locked = 1'b1;
                model_off = k;
                break;
            end
        end
        if (model_locked) begin
            s = base - WORD_W + model_off;
            for (int j = 0; j < WORD_W; j++)
                g[j] = stream[s + j];
            check_group(g, rx_rd, ce, de);
            if ((ce || de) && model_count < 15)
                model_count++;
            care = group_at.exists(s);
            exp_q.push_back({4'(model_count), ce, de, care, care ? group_at[s] : 9'h0});
        end
    endfunction

    // cuts the pending bits into words, one per cycle
    task automatic send_stream();
        logic [WORD_W-1:0] w;
        while (pending.size() >= WORD_W) begin
            for (int i = 0; i < WORD_W; i++)
                w[i] = pending.pop_front();
            @(negedge decode_clk);
            rx_word  = w;
            rx_valid = 1'b1;
            model_word(w);
        end
        @(negedge decode_clk);
        rx_valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 50) begin
            @(negedge decode_clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s timed out with %0d bytes still missing", test_name, exp_q.size());
        end
    endtask

    task automatic report_value(input string field, input int expv, input int actv);
        errors++;
        $display("Error %s %s expected %0h actual %0h", test_name, field, expv, actv);
    endtask

    // ----------------------------------------------------------------------
    // compare
    // ----------------------------------------------------------------------
    always @(posedge decode_clk or posedge decode_reset) begin
        if (decode_reset)
            vhist <= '0;
        else
            vhist <= {vhist[1:0], rx_valid};
    end

    always @(negedge decode_clk) begin : compare_outputs
        logic [15:0] e;
        if (out_byte_valid) begin
            checks++;
            // output must trail its word by three cycles
            if (!vhist[2]) begin
                errors++;
                $display("%s output byte without a word three cycles earlier", test_name);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s output byte arrived with nothing expected", test_name);
            end else begin
                e = exp_q.pop_front();
                if (e[9] && out_byte != e[7:0])
                    report_value("byte", e[7:0], out_byte);
                if (e[9] && out_is_k != e[8])
                    report_value("k_flag", e[8], out_is_k);
                if (out_disp_err != e[10])
                    report_value("disp_err", e[10], out_disp_err);
                if (out_code_err != e[11])
                    report_value("code_err", e[11], out_code_err);
                if (out_err_count != e[15:12])
                    report_value("error_count", e[15:12], out_err_count);
            end
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        errors = 0;
        checks = 0;
        decode_reset = 1'b1;
        rx_word = '0;
        rx_valid = 1'b0;
        test_name = "reset";
        void'($urandom(51951));
        for (int i = 0; i < WORD_W; i++)
            stream.push_back(1'b0);
        repeat (3) @(posedge decode_clk);
        @(negedge decode_clk);
        decode_reset = 1'b0;

        test_name = "no_comma";
        repeat (40) pending.push_back(1'b0);
        send_stream();
        drain();
        if (out_locked !== 1'b0) begin
            errors++;
            $display("aligner locked on a stream that holds no comma");
        end
        if (out_err_count != 0)
            report_value("error_count", 0, out_err_count);

        test_name = "idle_lock";
        insert_bits($urandom % 10);
        repeat (8) put_code(K28_5, 1'b1);
        repeat (40) put_code($urandom, 1'b0);
        send_stream();
        drain();
        if (out_locked !== 1'b1) begin
            errors++;
            $display("aligner failed to lock on the idle stream");
        end

        // D3.0 always flips the disparity
        test_name = "all_codes";
        for (int want = 0; want < 2; want++) begin
            for (int c = 0; c < 256; c++) begin
                if (tx_rd != want)
                    put_code(8'h03, 1'b0);
                put_code(c, 1'b0);
            end
            for (int c = 0; c < 12; c++) begin
                if (tx_rd != want)
                    put_code(8'h03, 1'b0);
                put_code(k_codes[c], 1'b1);
                // keeps K28.7 from forming a comma with its neighbour
                if (k_codes[c] == K28_7)
                    put_code(8'h00, 1'b0);
            end
        end
        send_stream();
        drain();

        test_name = "relock";
        repeat (10) put_code($urandom, 1'b0);
        insert_bits(1 + $urandom % 9);
        repeat (4) put_code(K28_5, 1'b1);
        repeat (30) put_code($urandom, 1'b0);
        send_stream();
        drain();

        test_name = "bit_flips";
        repeat (24) begin
            put_code($urandom, 1'b0);
            put_code($urandom, 1'b0);
            flip_bit($urandom % WORD_W);
            put_code(K28_5, 1'b1);
        end
        repeat (4) put_code(K28_5, 1'b1);
        send_stream();
        drain();
        if (out_err_count != 4'hF)
            report_value("saturated_count", 15, out_err_count);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* decode_rx_top.f */
+incdir+testbench
rtl/line_code_pkg.sv
rtl/rx_status_pkg.sv
rtl/comma_aligner.sv
rtl/decode_8b10b.sv
rtl/disparity_checker.sv
rtl/rx_byte_output.sv
rtl/decode_rx_top.sv
testbench/tb_decode_rx_top.sv
